// File: project.f
source/host_pkg.sv
source/host_req_port.sv
source/cmd_fifo.sv
source/l2_banks.sv
source/host_exec.sv
source/host_domain.sv
testbench/tb_host_domain.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the host domain testbench with Verilator
set -u
cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f project.f --top-module tb_host_domain \
  --Mdir "$BUILD_DIR" -o sim_host_domain
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

"./$BUILD_DIR/sim_host_domain" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG_FILE"; then
  exit 0
fi
echo "Pass message not found in $LOG_FILE"
exit 1

// File: source/cmd_fifo.sv
/*
 * Command FIFO
 * Synchronous circular buffer of host requests with full/empty flags
 */
`timescale 1ns/1ps

module cmd_fifo #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 push_i,
  input  host_pkg::host_req_t  push_data_i,
  output logic                 full_o,
  input  logic                 pop_i,
  output host_pkg::host_req_t  pop_data_o,
  output logic                 empty_o
);

  import host_pkg::*;

  localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  host_req_t         mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  count_q;

  assign full_o     = (count_q == CNT_W'(FIFO_DEPTH));
  assign empty_o    = (count_q == '0);
  assign pop_data_o = mem_q[rd_ptr_q];

  // Pointer advance with wrap for non power of two depths
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) wr_ptr_q <= ptr_next(wr_ptr_q);
      if (pop_i) rd_ptr_q <= ptr_next(rd_ptr_q);
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_i) mem_q[wr_ptr_q] <= push_data_i;
  end

  a_no_push_full: assert property (
    @(posedge clk_i) disable iff (reset_i) push_i |-> !full_o
  );

  a_no_pop_empty: assert property (
    @(posedge clk_i) disable iff (reset_i) pop_i |-> !empty_o
  );

endmodule

// File: source/host_domain.sv
/*
 * Host domain top level
 * Request port, command FIFO and executor with the L2 banks
 */
`timescale 1ns/1ps

module host_domain #(
  parameter int unsigned NB_BANKS   = 4,
  parameter int unsigned BANK_WORDS = 64,
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 req_i,
  input  host_pkg::host_req_t  req_data_i,
  output logic                 ack_o,
  output logic                 rsp_req_o,
  output host_pkg::host_rsp_t  rsp_data_o,
  input  logic                 rsp_ack_i
);

  import host_pkg::*;

  logic       push;
  logic       full;
  host_req_t  push_data;
  logic       pop;
  logic       empty;
  host_req_t  pop_data;

  host_req_port u_host_req_port (
    .clk_i       ( clk_i      ),
    .reset_i     ( reset_i    ),
    .req_i       ( req_i      ),
    .req_data_i  ( req_data_i ),
    .ack_o       ( ack_o      ),
    .full_i      ( full       ),
    .push_o      ( push       ),
    .push_data_o ( push_data  )
  );

  cmd_fifo #(
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) u_cmd_fifo (
    .clk_i       ( clk_i     ),
    .reset_i     ( reset_i   ),
    .push_i      ( push      ),
    .push_data_i ( push_data ),
    .full_o      ( full      ),
    .pop_i       ( pop       ),
    .pop_data_o  ( pop_data  ),
    .empty_o     ( empty     )
  );

  host_exec #(
    .NB_BANKS   ( NB_BANKS   ),
    .BANK_WORDS ( BANK_WORDS )
  ) u_host_exec (
    .clk_i      ( clk_i      ),
    .reset_i    ( reset_i    ),
    .empty_i    ( empty      ),
    .pop_data_i ( pop_data   ),
    .pop_o      ( pop        ),
    .rsp_req_o  ( rsp_req_o  ),
    .rsp_data_o ( rsp_data_o ),
    .rsp_ack_i  ( rsp_ack_i  )
  );

endmodule

// File: source/host_exec.sv
/*
 * Host command executor
 * Pops commands, runs L2 or config register accesses and returns
 * one response per command over the four-phase egress link
 */
`timescale 1ns/1ps

module host_exec #(
  parameter int unsigned NB_BANKS   = 4,
  parameter int unsigned BANK_WORDS = 64
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 empty_i,
  input  host_pkg::host_req_t  pop_data_i,
  output logic                 pop_o,
  output logic                 rsp_req_o,
  output host_pkg::host_rsp_t  rsp_data_o,
  input  logic                 rsp_ack_i
);

  import host_pkg::*;

  localparam int unsigned L2_WORDS  = NB_BANKS * BANK_WORDS;
  localparam int unsigned CFG_IDX_W = $clog2(CFG_WORDS);

  // Region codes
  localparam logic [1:0] REGION_L2   = 2'd0;
  localparam logic [1:0] REGION_CFG  = 2'd1;
  localparam logic [1:0] REGION_NONE = 2'd2;

  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    RESPOND,
    WAIT_DROP
  } exec_state_e;

  exec_state_e        state_q, state_d;
  host_req_t          cmd_q;
  logic [1:0]         region_q;
  logic [1:0]         region_d;
  host_rsp_t          rsp_q, rsp_d;
  logic [DATA_W-1:0]  cfg_q [CFG_WORDS];
  logic [DATA_W-1:0]  mem_rdata;
  logic               mem_en;
  logic               cfg_we;

  function automatic logic [1:0] decode_region(input logic [ADDR_W-1:0] addr);
    if (32'(addr) < L2_WORDS) begin
      return REGION_L2;
    end
    if (addr >= CFG_BASE && 32'(addr) < 32'(CFG_BASE) + CFG_WORDS) begin
      return REGION_CFG;
    end
    return REGION_NONE;
  endfunction

  assign region_d = decode_region(pop_data_i.addr);

  // Pop and issue the access in the same cycle
  assign pop_o  = (state_q == IDLE) && !empty_i;
  assign mem_en = pop_o && (region_d == REGION_L2);
  assign cfg_we = pop_o && (region_d == REGION_CFG) && (pop_data_i.op == OP_WRITE);

  l2_banks #(
    .NB_BANKS   ( NB_BANKS   ),
    .BANK_WORDS ( BANK_WORDS )
  ) u_l2_banks (
    .clk_i       ( clk_i                        ),
    .mem_en_i    ( mem_en                       ),
    .mem_we_i    ( pop_data_i.op == OP_WRITE    ),
    .mem_addr_i  ( pop_data_i.addr              ),
    .mem_wdata_i ( pop_data_i.wdata             ),
    .mem_rdata_o ( mem_rdata                    )
  );

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:      if (pop_o) state_d = ACCESS;
      ACCESS:    state_d = RESPOND;
      RESPOND:   if (rsp_ack_i) state_d = WAIT_DROP;
      // No new command before the host releases ack
      WAIT_DROP: if (!rsp_ack_i) state_d = IDLE;
      default:   state_d = IDLE;
    endcase
  end

  // Response built in ACCESS, L2 read data is valid here
  always_comb begin
    rsp_d.op    = cmd_q.op;
    rsp_d.error = (region_q == REGION_NONE);
    rsp_d.rdata = '0;
    if (cmd_q.op == OP_READ) begin
      case (region_q)
        REGION_L2:  rsp_d.rdata = mem_rdata;
        REGION_CFG: rsp_d.rdata = cfg_q[cmd_q.addr[CFG_IDX_W-1:0]];
        default:    rsp_d.rdata = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
      for (int i = 0; i < CFG_WORDS; i++) begin
        cfg_q[i] <= '0;
      end
    end else begin
      state_q <= state_d;
      if (cfg_we) cfg_q[pop_data_i.addr[CFG_IDX_W-1:0]] <= pop_data_i.wdata;
    end
  end

  // Command and response payload
  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      cmd_q    <= pop_data_i;
      region_q <= region_d;
    end
    if (state_q == ACCESS) rsp_q <= rsp_d;
  end

  assign rsp_req_o  = (state_q == RESPOND);
  assign rsp_data_o = rsp_q;

  a_rsp_stable: assert property (
    @(posedge clk_i) disable iff (reset_i)
    rsp_req_o && !rsp_ack_i |=> rsp_req_o && $stable(rsp_data_o)
  );

endmodule

// File: source/host_pkg.sv
/*
 * Host domain package
 * Widths, address map, opcode and the request/response structs
 */

package host_pkg;

  // Word address and data widths
  localparam int unsigned ADDR_W = 16;
  localparam int unsigned DATA_W = 32;

  // Config scratch region, L2 always starts at word 0
  localparam logic [ADDR_W-1:0] CFG_BASE  = 16'h8000;
  localparam int unsigned       CFG_WORDS = 4;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } host_op_e;

  // 1 + 16 + 32 = 49 bits
  typedef struct packed {
    host_op_e            op;
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   wdata;
  } host_req_t;

  // 1 + 1 + 32 = 34 bits
  typedef struct packed {
    host_op_e            op;
    logic                error;
    logic [DATA_W-1:0]   rdata;
  } host_rsp_t;

endpackage

// File: source/host_req_port.sv
/*
 * Host request port
 * Four-phase ingress that pushes each request once into the command FIFO
 */
`timescale 1ns/1ps

module host_req_port (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 req_i,
  input  host_pkg::host_req_t  req_data_i,
  output logic                 ack_o,
  input  logic                 full_i,
  output logic                 push_o,
  output host_pkg::host_req_t  push_data_o
);

  import host_pkg::*;

  typedef enum logic {
    IDLE,
    HOLD
  } port_state_e;

  port_state_e state_q, state_d;

  // Accept only from IDLE and wait there while the FIFO is full
  assign push_o      = (state_q == IDLE) && req_i && !full_i;
  assign push_data_o = req_data_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: if (push_o) state_d = HOLD;
      // Hold ack until the host drops req
      HOLD: if (!req_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
      ack_o   <= 1'b0;
    end else begin
      state_q <= state_d;
      ack_o   <= (state_d == HOLD);
    end
  end

  // ack only answers a request the host held when it was accepted
  a_ack_needs_req: assert property (
    @(posedge clk_i) disable iff (reset_i)
    $rose(ack_o) |-> $past(req_i)
  );

endmodule

// File: source/l2_banks.sv
/*
 * Banked L2 scratchpad
 * Word-interleaved banks, low address bits pick the bank, one-cycle read
 */
`timescale 1ns/1ps

module l2_banks #(
  parameter int unsigned NB_BANKS   = 4,
  parameter int unsigned BANK_WORDS = 64
) (
  input  logic                         clk_i,
  input  logic                         mem_en_i,
  input  logic                         mem_we_i,
  input  logic [host_pkg::ADDR_W-1:0]  mem_addr_i,
  input  logic [host_pkg::DATA_W-1:0]  mem_wdata_i,
  output logic [host_pkg::DATA_W-1:0]  mem_rdata_o
);

  import host_pkg::*;

  // NB_BANKS is a power of two, at least 2
  localparam int unsigned BANK_W = $clog2(NB_BANKS);
  localparam int unsigned ROW_W  = $clog2(BANK_WORDS);

  logic [BANK_W-1:0]  bank_sel;
  logic [ROW_W-1:0]   row;
  logic [BANK_W-1:0]  bank_sel_q;
  logic [DATA_W-1:0]  bank_rdata [NB_BANKS];

  assign bank_sel = mem_addr_i[BANK_W-1:0];
  assign row      = mem_addr_i[BANK_W +: ROW_W];

  for (genvar b = 0; b < NB_BANKS; b++) begin : g_bank
    logic [DATA_W-1:0] mem_q [BANK_WORDS];
    logic              bank_en;

    assign bank_en = mem_en_i && (bank_sel == BANK_W'(b));

    always_ff @(posedge clk_i) begin
      if (bank_en) begin
        if (mem_we_i) begin
          mem_q[row] <= mem_wdata_i;
        end else begin
          bank_rdata[b] <= mem_q[row];
        end
      end
    end
  end

  // Remember which bank answers next cycle
  always_ff @(posedge clk_i) begin
    if (mem_en_i) bank_sel_q <= bank_sel;
  end

  assign mem_rdata_o = bank_rdata[bank_sel_q];

endmodule

// File: testbench/tb_host_domain.sv
/*
 * Host domain testbench
 * LFSR stimulus over both four-phase links checked against a reference model
 */
`timescale 1ns/1ps

module tb_host_domain;

  import host_pkg::*;

  localparam int unsigned L2_WORDS = 4 * 64;
  localparam int          TIMEOUT  = 2000;
  localparam logic [31:0] SEED     = 32'hdf8b_42d5;

  logic       clk;
  logic       reset;
  logic       req;
  host_req_t  req_data;
  logic       ack;
  logic       rsp_req;
  host_rsp_t  rsp_data;
  logic       rsp_ack;

  // Reference model state
  logic [DATA_W-1:0]  l2_model [L2_WORDS];
  logic               l2_written [L2_WORDS];
  logic [DATA_W-1:0]  cfg_model [CFG_WORDS];
  host_rsp_t          exp_q [$];
  logic               exp_chk_q [$];

  logic [31:0]  stim_lfsr;
  logic [31:0]  ack_lfsr;
  logic         slow_ack;
  int           errors;
  int           rsp_errors;
  int           req_count;
  int           rsp_count;

  host_domain u_host_domain (
    .clk_i      ( clk      ),
    .reset_i    ( reset    ),
    .req_i      ( req      ),
    .req_data_i ( req_data ),
    .ack_o      ( ack      ),
    .rsp_req_o  ( rsp_req  ),
    .rsp_data_o ( rsp_data ),
    .rsp_ack_i  ( rsp_ack  )
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(inout logic [31:0] state, input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      state = lfsr_step(state);
      val   = {val[30:0], state[0]};
    end
    return val;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("errors: %0d, requests: %0d, responses: %0d",
             errors + rsp_errors + 1, req_count, rsp_count);
    $display("SOME TESTS FAILED");
    $finish;
  endtask

  // Updates the model, queues the expected response and runs the handshake
  task automatic send_req(input host_op_e op, input logic [ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] wdata);
    host_rsp_t exp;
    logic      chk;
    int        a;
    int        t;
    a         = int'(addr);
    exp.op    = op;
    exp.error = 1'b0;
    exp.rdata = '0;
    chk       = (op == OP_READ);
    if (a < L2_WORDS) begin
      if (op == OP_WRITE) begin
        l2_model[a]   = wdata;
        l2_written[a] = 1'b1;
      end else begin
        exp.rdata = l2_model[a];
        chk       = l2_written[a];
      end
    end else if (a >= int'(CFG_BASE) && a < int'(CFG_BASE) + CFG_WORDS) begin
      if (op == OP_WRITE) begin
        cfg_model[a - int'(CFG_BASE)] = wdata;
      end else begin
        exp.rdata = cfg_model[a - int'(CFG_BASE)];
      end
    end else begin
      // Unmapped answers error with zero data for either op
      exp.error = 1'b1;
      chk       = 1'b1;
    end
    exp_q.push_back(exp);
    exp_chk_q.push_back(chk);
    req_count++;

    @(negedge clk);
    req            = 1'b1;
    req_data.op    = op;
    req_data.addr  = addr;
    req_data.wdata = wdata;
    t = 0;
    while (!ack) begin
      @(negedge clk);
      t++;
      if (t > TIMEOUT) abort_run("Timeout waiting for ack_o to rise");
    end
    req = 1'b0;
    t = 0;
    while (ack) begin
      @(negedge clk);
      t++;
      if (t > TIMEOUT) abort_run("Timeout waiting for ack_o to fall");
    end
  endtask

  // Host side of the response link
  initial begin : response_side
    host_rsp_t exp;
    logic      chk;
    int        delay;
    int        t;
    rsp_ack    = 1'b0;
    ack_lfsr   = SEED;
    rsp_errors = 0;
    rsp_count  = 0;
    forever begin
      @(negedge clk);
      if (rsp_req && !rsp_ack) begin
        if (exp_q.size() == 0) begin
          $display("A response arrived with no request outstanding");
          rsp_errors++;
        end else begin
          exp = exp_q.pop_front();
          chk = exp_chk_q.pop_front();
          if (rsp_data.op != exp.op) begin
            $display("ERROR rsp_data_o.op got %h exp %h", rsp_data.op, exp.op);
            rsp_errors++;
          end
          if (rsp_data.error != exp.error) begin
            $display("ERROR rsp_data_o.error got %h exp %h", rsp_data.error, exp.error);
            rsp_errors++;
          end
          if (chk && rsp_data.rdata != exp.rdata) begin
            $display("ERROR rsp_data_o.rdata got %h exp %h", rsp_data.rdata, exp.rdata);
            rsp_errors++;
          end
        end
        rsp_count++;
        delay = int'(take_bits(ack_lfsr, 3));
        if (slow_ack) delay = delay + 8 + int'(take_bits(ack_lfsr, 4));
        repeat (delay) @(negedge clk);
        rsp_ack = 1'b1;
        t = 0;
        while (rsp_req) begin
          @(negedge clk);
          t++;
          if (t > TIMEOUT) abort_run("Timeout waiting for rsp_req_o to fall");
        end
        rsp_ack = 1'b0;
      end
    end
  end

  initial begin : main_flow
    logic [ADDR_W-1:0]  waddr [$];
    logic [ADDR_W-1:0]  bad_addr [4];
    logic [ADDR_W-1:0]  addr;
    logic [31:0]        base;
    int                 sel;
    int                 t;
    reset     = 1'b1;
    req       = 1'b0;
    req_data  = '0;
    slow_ack  = 1'b0;
    errors    = 0;
    req_count = 0;
    stim_lfsr = SEED;
    for (int i = 0; i < L2_WORDS; i++) l2_written[i] = 1'b0;
    for (int i = 0; i < CFG_WORDS; i++) cfg_model[i] = '0;

    // Outputs stay low in reset and just after
    for (int i = 0; i < 19; i++) begin
      @(negedge clk);
      if (i == 15) reset = 1'b0;
      if (ack) begin
        $display("ERROR ack_o got %h exp 0", ack);
        errors++;
      end
      if (rsp_req) begin
        $display("ERROR rsp_req_o got %h exp 0", rsp_req);
        errors++;
      end
    end
    for (int i = 0; i < CFG_WORDS; i++) send_req(OP_READ, CFG_BASE + ADDR_W'(i), '0);

    // L2 writes over consecutive addresses, then reads
    base = take_bits(stim_lfsr, 8);
    for (int i = 0; i < 32; i++) begin
      addr = ADDR_W'((base + 32'(i)) % L2_WORDS);
      waddr.push_back(addr);
      send_req(OP_WRITE, addr, take_bits(stim_lfsr, 32));
    end
    foreach (waddr[i]) send_req(OP_READ, waddr[i], '0);
    repeat (8) send_req(OP_READ, ADDR_W'(take_bits(stim_lfsr, 8)), '0);

    // Config registers next to L2 words with the same low bits
    for (int i = 0; i < CFG_WORDS; i++) begin
      send_req(OP_WRITE, CFG_BASE + ADDR_W'(i), take_bits(stim_lfsr, 32));
      send_req(OP_WRITE, ADDR_W'(i), take_bits(stim_lfsr, 32));
    end
    for (int i = 0; i < CFG_WORDS; i++) begin
      send_req(OP_READ, CFG_BASE + ADDR_W'(i), '0);
      send_req(OP_READ, ADDR_W'(i), '0);
    end

    // Unmapped accesses, including aliases of L2 and config
    bad_addr[0] = 16'h4000;
    bad_addr[1] = CFG_BASE + 16'd4;
    bad_addr[2] = 16'h0100;
    bad_addr[3] = 16'hffff;
    foreach (bad_addr[i]) send_req(OP_WRITE, bad_addr[i], take_bits(stim_lfsr, 32));
    foreach (bad_addr[i]) send_req(OP_READ, bad_addr[i], '0);
    for (int i = 0; i < CFG_WORDS; i++) send_req(OP_READ, CFG_BASE + ADDR_W'(i), '0);
    for (int i = 0; i < 4; i++) send_req(OP_READ, ADDR_W'(i), '0);
    foreach (waddr[i]) send_req(OP_READ, waddr[i], '0);

    // Back-pressure burst with slow response acks
    slow_ack = 1'b1;
    repeat (24) begin
      sel = int'(take_bits(stim_lfsr, 2));
      case (sel)
        0, 1:    addr = ADDR_W'(take_bits(stim_lfsr, 8));
        2:       addr = CFG_BASE + ADDR_W'(take_bits(stim_lfsr, 2));
        default: addr = 16'h0100 + ADDR_W'(take_bits(stim_lfsr, 8));
      endcase
      send_req(take_bits(stim_lfsr, 1) == 32'd1 ? OP_WRITE : OP_READ, addr,
               take_bits(stim_lfsr, 32));
    end
    slow_ack = 1'b0;

    t = 0;
    while (rsp_count != req_count || rsp_req || rsp_ack) begin
      @(negedge clk);
      t++;
      if (t > TIMEOUT) abort_run("Timeout waiting for the last responses");
    end
    repeat (8) @(negedge clk);
    if (rsp_req) begin
      $display("An extra response was raised after the last request");
      errors++;
    end

    $display("errors: %0d, requests: %0d, responses: %0d",
             errors + rsp_errors, req_count, rsp_count);
    if (errors + rsp_errors == 0 && rsp_count == req_count) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
